/* source/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Basic types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] lc3b_word;

    // Only the memory opcodes are named. Every other encoding is a
    // non-memory instruction that passes through the unit.
    typedef enum logic [3:0] {
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef struct packed {
        lc3b_opcode  opcode;
        logic [2:0]  dr_sr;
        logic [2:0]  base_r;
        logic [5:0]  offset6;
    } lc3b_mem_fmt;

    typedef struct packed {
        lc3b_opcode  opcode;
        logic [3:0]  unused;
        logic [7:0]  trapvect8;
    } lc3b_trap_fmt;

    // One instruction word, read in the format its opcode calls for.
    typedef union packed {
        lc3b_mem_fmt  mem_fmt;
        lc3b_trap_fmt trap_fmt;
    } lc3b_instr;

    typedef struct packed {
        lc3b_opcode  opcode;
        logic [2:0]  dest_reg;
        logic        reg_write;
        logic        is_mem;
    } lc3b_control_word;

    typedef struct packed {
        logic n;
        logic z;
        logic p;
    } lc3b_cc;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode classes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic is_load(input lc3b_opcode op);
        return (op == op_ldb) || (op == op_ldr) || (op == op_ldi);
    endfunction

    function automatic logic is_indirect(input lc3b_opcode op);
        return (op == op_ldi) || (op == op_sti);
    endfunction

    function automatic logic is_memory(input lc3b_opcode op);
        return is_load(op) || is_indirect(op) || (op == op_stb) ||
               (op == op_str) || (op == op_trap);
    endfunction

endpackage

`default_nettype wire

/* source/stage_if.sv */
`default_nettype none

// Contents of the execute register, seen by the memory stage and the
// result register.
interface stage_if;

    logic                         valid;
    lc3b_pkg::lc3b_control_word   ctrl;
    lc3b_pkg::lc3b_word           address;
    lc3b_pkg::lc3b_word           src_data;
    lc3b_pkg::lc3b_word           pc;

    modport exec (
        output valid,
        output ctrl,
        output address,
        output src_data,
        output pc
    );

    modport mem (
        input valid,
        input ctrl,
        input address,
        input src_data,
        input pc
    );

    modport result (
        input valid,
        input ctrl,
        input address,
        input src_data,
        input pc
    );

endinterface

`default_nettype wire

/* source/mem_decode.sv */
`default_nettype none

module mem_decode (
    input  wire lc3b_pkg::lc3b_instr         instr,
    output lc3b_pkg::lc3b_control_word       ctrl,
    output lc3b_pkg::lc3b_word               offset,
    output lc3b_pkg::lc3b_word               trap_addr
);

    lc3b_pkg::lc3b_opcode opcode;
    lc3b_pkg::lc3b_word   offset_sext;

    // The opcode sits in the same bits in both formats.
    assign opcode = instr.mem_fmt.opcode;

    assign offset_sext = {{10{instr.mem_fmt.offset6[5]}}, instr.mem_fmt.offset6};

    // Trap vectors index a table of words.
    assign trap_addr = {7'd0, instr.trap_fmt.trapvect8, 1'b0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Offset scaling
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (opcode)
            lc3b_pkg::op_ldb,
            lc3b_pkg::op_stb: begin
                offset = offset_sext;
            end
            lc3b_pkg::op_ldr,
            lc3b_pkg::op_str,
            lc3b_pkg::op_ldi,
            lc3b_pkg::op_sti: begin
                offset = {offset_sext[14:0], 1'b0};
            end
            default: begin
                offset = '0;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ctrl.opcode    = opcode;
        ctrl.is_mem    = lc3b_pkg::is_memory(opcode);
        ctrl.reg_write = lc3b_pkg::is_load(opcode) || (opcode == lc3b_pkg::op_trap);

        // TRAP links through R7.
        if (opcode == lc3b_pkg::op_trap) begin
            ctrl.dest_reg = 3'd7;
        end else if (lc3b_pkg::is_load(opcode)) begin
            ctrl.dest_reg = instr.mem_fmt.dr_sr;
        end else begin
            ctrl.dest_reg = 3'd0;
        end
    end

endmodule

`default_nettype wire

/* source/addr_execute.sv */
`default_nettype none

module addr_execute (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         flush,
    input  wire                         advance,
    input  wire                         ready,
    input  wire                         inst_valid,
    input  wire lc3b_pkg::lc3b_instr    instr,
    input  wire lc3b_pkg::lc3b_word     pc,
    input  wire lc3b_pkg::lc3b_word     base_data,
    input  wire lc3b_pkg::lc3b_word     src_data,
    output logic                        accept,
    stage_if.exec                       ex
);

    lc3b_pkg::lc3b_control_word ctrl;
    lc3b_pkg::lc3b_word         offset;
    lc3b_pkg::lc3b_word         trap_addr;
    lc3b_pkg::lc3b_word         address;
    logic                       load;
    logic                       retire;

    mem_decode u_decode (
        .instr     (instr),
        .ctrl      (ctrl),
        .offset    (offset),
        .trap_addr (trap_addr)
    );

    assign address = (ctrl.opcode == lc3b_pkg::op_trap) ? trap_addr : base_data + offset;

    // The register frees up when its instruction retires in this cycle.
    assign retire = ex.valid && ready && advance;
    assign accept = advance && !flush && (!ex.valid || ready);
    assign load   = inst_valid && accept;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex.valid <= 1'b0;
        end else if (load) begin
            ex.valid <= 1'b1;
        end else if (retire) begin
            ex.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            ex.ctrl     <= ctrl;
            ex.address  <= address;
            ex.src_data <= src_data;
            ex.pc       <= pc;
        end
    end

endmodule

`default_nettype wire

/* source/mem_control.sv */
`default_nettype none

module mem_control (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       flush,
    input  wire                       advance,
    input  wire lc3b_pkg::lc3b_word   mem_rdata,
    input  wire                       data_response,
    stage_if.mem                      ex,
    output lc3b_pkg::lc3b_word        mem_address,
    output lc3b_pkg::lc3b_word        mem_wdata,
    output logic [1:0]                mem_byte_enable,
    output logic                      data_request,
    output logic                      write_enable,
    output lc3b_pkg::lc3b_word        mem_output,
    output logic                      ready
);

    typedef enum logic {
        first_hit,
        second_hit
    } state_t;

    state_t               state;
    state_t               next_state;
    lc3b_pkg::lc3b_word   pointer;
    logic                 indirect;
    logic                 get_rdata;

    assign indirect = ex.valid && lc3b_pkg::is_indirect(ex.ctrl.opcode);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and byte lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        mem_address     = '0;
        mem_wdata       = '0;
        mem_byte_enable = 2'b11;
        data_request    = 1'b0;
        write_enable    = 1'b0;
        mem_output      = '0;
        ready           = 1'b1;
        get_rdata       = 1'b0;

        // Non-memory instructions and an empty stage complete at once.
        if (!flush && ex.valid && ex.ctrl.is_mem) begin
            data_request = 1'b1;
            ready        = data_response;

            if (state == first_hit) begin
                mem_address = ex.address;
                case (ex.ctrl.opcode)
                    lc3b_pkg::op_ldb: begin
                        if (ex.address[0]) begin
                            mem_output = {8'd0, mem_rdata[15:8]};
                        end else begin
                            mem_output = {8'd0, mem_rdata[7:0]};
                        end
                    end
                    lc3b_pkg::op_stb: begin
                        write_enable = 1'b1;
                        if (ex.address[0]) begin
                            mem_wdata       = {ex.src_data[7:0], 8'd0};
                            mem_byte_enable = 2'b10;
                        end else begin
                            mem_wdata       = {8'd0, ex.src_data[7:0]};
                            mem_byte_enable = 2'b01;
                        end
                    end
                    lc3b_pkg::op_str: begin
                        write_enable = 1'b1;
                        mem_wdata    = ex.src_data;
                    end
                    lc3b_pkg::op_ldi,
                    lc3b_pkg::op_sti: begin
                        // The first read only fetches the pointer.
                        ready     = 1'b0;
                        get_rdata = data_response;
                    end
                    default: begin
                        mem_output = mem_rdata;
                    end
                endcase
            end else begin
                mem_address = pointer;
                case (ex.ctrl.opcode)
                    lc3b_pkg::op_sti: begin
                        write_enable = 1'b1;
                        mem_wdata    = ex.src_data;
                    end
                    default: begin
                        mem_output = mem_rdata;
                    end
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State and pointer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        next_state = state;
        if (flush) begin
            next_state = first_hit;
        end else begin
            case (state)
                first_hit: begin
                    if (indirect && data_response) begin
                        next_state = second_hit;
                    end
                end
                second_hit: begin
                    // The indirect access is repeated until it lands with advance.
                    if (data_response && advance) begin
                        next_state = first_hit;
                    end
                end
                default: begin
                    next_state = first_hit;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= first_hit;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (get_rdata) begin
            pointer <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* source/mem_result.sv */
`default_nettype none

module mem_result (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       flush,
    input  wire                       advance,
    input  wire                       ready,
    input  wire lc3b_pkg::lc3b_word   mem_output,
    stage_if.result                   ex,
    output logic                      wb_valid,
    output logic [2:0]                wb_reg,
    output lc3b_pkg::lc3b_word        wb_data,
    output lc3b_pkg::lc3b_cc          wb_cc,
    output logic                      jump_valid,
    output lc3b_pkg::lc3b_word        jump_pc
);

    logic              retire;
    logic              is_trap;
    lc3b_pkg::lc3b_cc  cc;

    assign retire  = ex.valid && ready && advance && !flush;
    assign is_trap = (ex.ctrl.opcode == lc3b_pkg::op_trap);

    assign cc.n = mem_output[15];
    assign cc.z = (mem_output == '0);
    assign cc.p = !mem_output[15] && (mem_output != '0);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wb_valid   <= 1'b0;
            jump_valid <= 1'b0;
        end else begin
            wb_valid   <= retire && ex.ctrl.reg_write;
            jump_valid <= retire && is_trap;
        end
    end

    // Payloads only change on retirement, so they keep their value under hold.
    always_ff @(posedge clk) begin
        if (retire && ex.ctrl.reg_write) begin
            wb_reg <= ex.ctrl.dest_reg;
            if (is_trap) begin
                wb_data <= ex.pc;
                wb_cc   <= '0;
            end else begin
                wb_data <= mem_output;
                wb_cc   <= cc;
            end
        end
        if (retire && is_trap) begin
            jump_pc <= mem_output;
        end
    end

endmodule

`default_nettype wire

/* source/mem_unit_top.sv */
`default_nettype none

module mem_unit_top (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       flush,
    input  wire                       hold,
    input  wire                       inst_valid,
    input  wire lc3b_pkg::lc3b_word   instr,
    input  wire lc3b_pkg::lc3b_word   pc,
    input  wire lc3b_pkg::lc3b_word   base_data,
    input  wire lc3b_pkg::lc3b_word   src_data,
    input  wire lc3b_pkg::lc3b_word   mem_rdata,
    input  wire                       data_response,
    output logic                      accept,
    output lc3b_pkg::lc3b_word        mem_address,
    output lc3b_pkg::lc3b_word        mem_wdata,
    output logic [1:0]                mem_byte_enable,
    output logic                      data_request,
    output logic                      write_enable,
    output logic                      wb_valid,
    output logic [2:0]                wb_reg,
    output lc3b_pkg::lc3b_word        wb_data,
    output lc3b_pkg::lc3b_cc          wb_cc,
    output logic                      jump_valid,
    output lc3b_pkg::lc3b_word        jump_pc
);

    logic                 advance;
    logic                 ready;
    lc3b_pkg::lc3b_word   mem_output;

    stage_if ex_if ();

    assign advance = !hold;

    addr_execute u_execute (
        .clk (clk), .rst (rst), .flush (flush), .advance (advance), .ready (ready),
        .inst_valid (inst_valid), .instr (lc3b_pkg::lc3b_instr'(instr)), .pc (pc),
        .base_data (base_data), .src_data (src_data), .accept (accept), .ex (ex_if.exec)
    );

    mem_control u_control (
        .clk (clk), .rst (rst), .flush (flush), .advance (advance),
        .mem_rdata (mem_rdata), .data_response (data_response), .ex (ex_if.mem),
        .mem_address (mem_address), .mem_wdata (mem_wdata),
        .mem_byte_enable (mem_byte_enable), .data_request (data_request),
        .write_enable (write_enable), .mem_output (mem_output), .ready (ready)
    );

    mem_result u_result (
        .clk (clk), .rst (rst), .flush (flush), .advance (advance), .ready (ready),
        .mem_output (mem_output), .ex (ex_if.result), .wb_valid (wb_valid),
        .wb_reg (wb_reg), .wb_data (wb_data), .wb_cc (wb_cc),
        .jump_valid (jump_valid), .jump_pc (jump_pc)
    );

endmodule

`default_nettype wire

/* bench/mem_unit_model.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory and reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// The memory answering the DUT, and the copy the model writes itself.
logic [15:0] mem [0:255];
logic [15:0] ref_mem [0:255];

// Instruction held in the model's execute register.
logic        slot_valid;
logic        slot_second;
logic [15:0] slot_instr;
logic [15:0] slot_addr;
logic [15:0] slot_src;
logic [15:0] slot_pc;
logic [15:0] slot_pointer;

typedef struct packed {
    logic        wb;
    logic        jmp;
    logic [2:0]  wreg;
    logic [15:0] data;
    logic [2:0]  cc;
    logic [15:0] jpc;
    logic [31:0] cycle;
} result_t;

result_t result_q[$];

function automatic logic is_memory_op(input logic [3:0] op);
    return op inside {op_ldb, op_stb, op_ldr, op_str, op_ldi, op_sti, op_trap};
endfunction

function automatic logic [15:0] fill_word(input logic [7:0] index);
    return (index[3:0] == 4'd0) ? 16'h0000 : {index ^ 8'hc3, ~index};
endfunction

function automatic logic [15:0] effective_address(input logic [15:0] ins,
                                                  input logic [15:0] base);
    logic [15:0] off;
    off = {{10{ins[5]}}, ins[5:0]};
    if (ins[15:12] == op_trap) begin
        return {7'd0, ins[7:0], 1'b0};
    end else if (ins[15:12] == op_ldb || ins[15:12] == op_stb) begin
        return base + off;
    end
    return base + {off[14:0], 1'b0};
endfunction

// Request the DUT should be making for the instruction in the slot.
task automatic expected_access(output logic [15:0] addr, output logic we,
                               output logic [15:0] wdata, output logic [1:0] be);
    logic [3:0] op;
    op    = slot_instr[15:12];
    addr  = slot_second ? slot_pointer : slot_addr;
    we    = slot_second ? (op == op_sti) : (op == op_stb || op == op_str);
    wdata = slot_src;
    be    = 2'b11;
    if (op == op_stb) begin
        be    = addr[0] ? 2'b10 : 2'b01;
        wdata = addr[0] ? {slot_src[7:0], 8'd0} : {8'd0, slot_src[7:0]};
    end
endtask

function automatic result_t retire_result(input logic [31:0] cyc);
    result_t     r;
    logic [3:0]  op;
    logic [15:0] a;
    logic [15:0] w;
    op      = slot_instr[15:12];
    r       = '0;
    r.cycle = cyc;
    a       = (op == op_ldi) ? slot_pointer : slot_addr;
    w       = ref_mem[a[8:1]];
    if (op == op_trap) begin
        r.wb   = 1'b1;
        r.jmp  = 1'b1;
        r.wreg = 3'd7;
        r.data = slot_pc;
        r.jpc  = w;
    end else if (op == op_ldb || op == op_ldr || op == op_ldi) begin
        if (op == op_ldb) begin
            w = a[0] ? {8'd0, w[15:8]} : {8'd0, w[7:0]};
        end
        r.wb   = 1'b1;
        r.wreg = slot_instr[11:9];
        r.data = w;
        // Exactly one of n, z and p is set for a loaded value.
        if (w == 16'd0) begin
            r.cc = 3'b010;
        end else if (w[15]) begin
            r.cc = 3'b100;
        end else begin
            r.cc = 3'b001;
        end
    end
    return r;
endfunction

/* bench/mem_unit_tb.sv */
`default_nettype none

module mem_unit_tb;

    localparam logic [3:0] op_ldb  = 4'h2;
    localparam logic [3:0] op_stb  = 4'h3;
    localparam logic [3:0] op_ldr  = 4'h6;
    localparam logic [3:0] op_str  = 4'h7;
    localparam logic [3:0] op_ldi  = 4'ha;
    localparam logic [3:0] op_sti  = 4'hb;
    localparam logic [3:0] op_trap = 4'hf;
    localparam int reset_cycles    = 10;
    localparam int num_tests       = 6;
    localparam int per_test        = 60;
    localparam int timeout_cycles  = num_tests * per_test * 16 + reset_cycles;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        hold;
    logic        inst_valid;
    logic [15:0] instr;
    logic [15:0] pc;
    logic [15:0] base_data;
    logic [15:0] src_data;
    logic [15:0] mem_rdata;
    logic        data_response;
    logic        accept;
    logic [15:0] mem_address;
    logic [15:0] mem_wdata;
    logic [1:0]  mem_byte_enable;
    logic        data_request;
    logic        write_enable;
    logic        wb_valid;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    logic [2:0]  wb_cc;
    logic        jump_valid;
    logic [15:0] jump_pc;

    integer seed;
    int     cycle;
    int     errors;
    int     accepted;
    int     resp_wait;
    string  test_names [0:num_tests-1];

    `include "mem_unit_model.svh"

    mem_unit_top u_dut (
        .clk (clk), .rst (rst), .flush (flush), .hold (hold), .inst_valid (inst_valid),
        .instr (instr), .pc (pc), .base_data (base_data), .src_data (src_data),
        .mem_rdata (mem_rdata), .data_response (data_response), .accept (accept),
        .mem_address (mem_address), .mem_wdata (mem_wdata),
        .mem_byte_enable (mem_byte_enable), .data_request (data_request),
        .write_enable (write_enable), .wb_valid (wb_valid), .wb_reg (wb_reg),
        .wb_data (wb_data), .wb_cc (wb_cc), .jump_valid (jump_valid), .jump_pc (jump_pc)
    );

    assign mem_rdata = mem[mem_address[8:1]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic pick_opcode(input int test, output logic [3:0] op);
        logic [3:0] mem_ops [0:6];
        logic       coin;
        int         pick;
        mem_ops = '{op_ldb, op_stb, op_ldr, op_str, op_ldi, op_sti, op_trap};
        coin    = $random(seed);
        pick    = $unsigned($random(seed)) % 10;
        case (test)
            0: op = coin ? op_ldr : op_str;
            1: op = coin ? op_ldb : op_stb;
            2: op = coin ? op_ldi : op_sti;
            3: op = coin ? op_trap : op_ldr;
            default: begin
                op = (pick < 7) ? mem_ops[pick] : 4'($random(seed));
                while (pick >= 7 && is_memory_op(op)) begin
                    op = 4'($random(seed));
                end
            end
        endcase
    endtask

    task automatic drive_inputs(input int test, input logic active);
        logic [3:0] op;
        int         hold_pct;
        int         flush_pct;
        hold_pct   = (test == 4) ? 35 : 10;
        flush_pct  = (test == 5) ? 6 : 0;
        pick_opcode(test, op);
        instr      = {op, 12'($random(seed))};
        pc         = $random(seed);
        base_data  = $random(seed);
        src_data   = $random(seed);
        inst_valid = active && ($unsigned($random(seed)) % 10 < 7);
        hold       = active && ($unsigned($random(seed)) % 100 < hold_pct);
        flush      = active && ($unsigned($random(seed)) % 100 < flush_pct);
    endtask

    // One-cycle response after a random wait of 0 to 3 cycles.
    task automatic respond_memory();
        if (data_response) begin
            data_response = 1'b0;
            resp_wait     = -1;
        end else if (data_request) begin
            if (resp_wait < 0) begin
                resp_wait = $unsigned($random(seed)) % 4;
            end
            if (resp_wait == 0) begin
                data_response = 1'b1;
            end else begin
                resp_wait--;
            end
        end
    endtask

    task automatic monitor_cycle();
        logic        is_mem;
        logic        slot_ready;
        logic        retire;
        logic        exp_req;
        logic        exp_accept;
        logic [15:0] ea;
        logic        ewe;
        logic [15:0] ewd;
        logic [1:0]  ebe;
        result_t     r;
        is_mem     = slot_valid && is_memory_op(slot_instr[15:12]);
        slot_ready = !is_mem || (data_response &&
                     (slot_second || !(slot_instr[15:12] inside {op_ldi, op_sti})));
        retire     = slot_valid && slot_ready && !hold && !flush;
        exp_req    = is_mem && !flush;
        exp_accept = !hold && !flush && (!slot_valid || slot_ready);
        expected_access(ea, ewe, ewd, ebe);
        check_value("accept", exp_accept, accept);
        check_value("data_request", exp_req, data_request);
        if (exp_req && data_request) begin
            check_value("mem_address", ea, mem_address);
            check_value("write_enable", ewe, write_enable);
            if (ewe) begin
                check_value("mem_wdata", ewd, mem_wdata);
                check_value("mem_byte_enable", ebe, mem_byte_enable);
            end
        end
        if (result_q.size() != 0 && result_q[0].cycle == cycle - 1) begin
            r = result_q.pop_front();
            check_value("wb_valid", r.wb, wb_valid);
            check_value("jump_valid", r.jmp, jump_valid);
            if (r.wb) begin
                check_value("wb_reg", r.wreg, wb_reg);
                check_value("wb_data", r.data, wb_data);
                check_value("wb_cc", r.cc, wb_cc);
            end
            if (r.jmp) begin
                check_value("jump_pc", r.jpc, jump_pc);
            end
        end else begin
            check_value("wb_valid", 1'b0, wb_valid);
            check_value("jump_valid", 1'b0, jump_valid);
        end
        if (retire) begin
            r = retire_result(cycle);
            if (r.wb || r.jmp) begin
                result_q.push_back(r);
            end
        end
        if (data_request && data_response && write_enable) begin
            if (mem_byte_enable[0]) begin
                mem[mem_address[8:1]][7:0] = mem_wdata[7:0];
            end
            if (mem_byte_enable[1]) begin
                mem[mem_address[8:1]][15:8] = mem_wdata[15:8];
            end
        end
        if (exp_req && data_response) begin
            if (ewe && ebe[0]) begin
                ref_mem[ea[8:1]][7:0] = ewd[7:0];
            end
            if (ewe && ebe[1]) begin
                ref_mem[ea[8:1]][15:8] = ewd[15:8];
            end
            if (!slot_second && slot_instr[15:12] inside {op_ldi, op_sti}) begin
                slot_second  = 1'b1;
                slot_pointer = ref_mem[slot_addr[8:1]];
            end
        end
        if (flush || retire) begin
            slot_valid  = 1'b0;
            slot_second = 1'b0;
        end
        if (inst_valid && exp_accept) begin
            slot_valid  = 1'b1;
            slot_second = 1'b0;
            slot_instr  = instr;
            slot_addr   = effective_address(instr, base_data);
            slot_src    = src_data;
            slot_pc     = pc;
            accepted++;
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle > timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Test FAILED");
            $finish;
        end else if (!rst) begin
            monitor_cycle();
        end
    end

    initial begin
        int start_count;
        int start_errors;
        seed          = 32'hd9f5_4acd;
        cycle         = 0;
        errors        = 0;
        accepted      = 0;
        resp_wait     = -1;
        slot_valid    = 1'b0;
        slot_second   = 1'b0;
        data_response = 1'b0;
        rst           = 1'b1;
        test_names    = '{"word access", "byte access", "indirect access", "trap",
                          "hold", "flush"};
        for (int i = 0; i < 256; i++) begin
            mem[i]     = fill_word(i[7:0]);
            ref_mem[i] = fill_word(i[7:0]);
        end
        drive_inputs(0, 1'b0);
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            start_count  = accepted;
            start_errors = errors;
            while (accepted - start_count < per_test) begin
                @(negedge clk);
                respond_memory();
                drive_inputs(t, 1'b1);
            end
            while (slot_valid || result_q.size() != 0 || wb_valid || jump_valid) begin
                @(negedge clk);
                respond_memory();
                drive_inputs(t, 1'b0);
            end
            $display("%s test: %0d instructions, %0d errors", test_names[t],
                     accepted - start_count, errors - start_errors);
        end
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("mem[%0d]", i), ref_mem[i], mem[i]);
        end
        $display("%0d tests, %0d instructions, %0d errors", num_tests, accepted, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
source/lc3b_pkg.sv
source/stage_if.sv
source/mem_decode.sv
source/addr_execute.sv
source/mem_control.sv
source/mem_result.sv
source/mem_unit_top.sv
bench/mem_unit_tb.sv
